/* wt_store_path.f */
design/cache_req_pkg.sv
design/be_bus_pkg.sv
design/store_buffer.sv
design/apb_store_port.sv
design/write_channel.sv
design/wt_store_path.sv
tb/wt_store_path_assertions.sv
tb/tb_wt_store_path.sv

/* run.sh */
#!/bin/sh
# build the store path testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_wt_store_path \
   -f wt_store_path.f \
   -Mdir obj_dir -o sim_tb \
   || { echo "build failed"; exit 1; }

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no pass message in log"; exit 1; }
exit 0

/* tb/tb_wt_store_path.sv */
`timescale 1ns/1ps

module tb_wt_store_path
   import cache_req_pkg::*;
   import be_bus_pkg::*;
();

   localparam int          CYCLE_LIMIT = 2000;   // tests need about 300
   localparam int          DRAIN_LIMIT = 200;    // per test, after the last write
   localparam logic [31:0] DATA_KEY    = 32'h5a5a_0000;

   logic              clk;
   logic              reset;
   apb_req_t          apb_req;
   logic              pready;
   logic              pslverr;
   logic [DATA_W-1:0] prdata;
   be_req_t           be_req;
   logic              be_ready;

   logic [31:0] lfsr        = 32'hb73f_f9d3;
   int          ready_mode  = 0;   // 0 low, 1 high, 2 random
   int          cycle_count = 0;
   int          write_count = 0;
   int          read_count  = 0;
   int          xfer_count  = 0;
   int          stall_count = 0;
   int          tb_errors   = 0;

   wt_store_path #(
      .WBUF_DEPTH (4)
   ) dut_i (
      .clk      (clk),
      .reset    (reset),
      .apb_req  (apb_req),
      .pready   (pready),
      .pslverr  (pslverr),
      .prdata   (prdata),
      .be_req   (be_req),
      .be_ready (be_ready)
   );

   bind wt_store_path wt_store_path_assertions chk_i (
      .clk      (clk),
      .reset    (reset),
      .apb_req  (apb_req),
      .pready   (pready),
      .pslverr  (pslverr),
      .prdata   (prdata),
      .be_req   (be_req),
      .be_ready (be_ready)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
      end
      return n;
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   function automatic word_t word_for(input waddr_t waddr);
      return DATA_W'(waddr) ^ DATA_KEY;
   endfunction

   function automatic strb_t strb_for(input waddr_t waddr);
      return {waddr[0], ~waddr[0], waddr[1], 1'b1};   // partial, never zero
   endfunction

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (!reset && be_req.valid && be_ready) begin
         xfer_count++;
      end
      if (apb_req.psel && apb_req.penable && apb_req.pwrite && !pready) begin
         stall_count++;
      end
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: run stopped after %0d cycles", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   // backend responder
   always @(posedge clk) begin
      int          mode;
      logic [31:0] bits;
      mode = ready_mode;
      #1;
      case (mode)
         0: be_ready = 1'b0;
         1: be_ready = 1'b1;
         default: begin
            draw_bits(1, bits);
            be_ready = bits[0];
         end
      endcase
   end

   // bus tasks start and end 1 ns after a rising edge
   task automatic apb_write(input addr_t addr);
      waddr_t waddr;
      waddr = addr[ADDR_W-1:NBYTES_W];
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b1;
      apb_req.paddr   = addr;
      apb_req.pwdata  = word_for(waddr);
      apb_req.pstrb   = strb_for(waddr);
      @(posedge clk);
      #1;
      apb_req.penable = 1'b1;
      @(negedge clk);
      while (!pready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      apb_req = '0;
      write_count++;
   endtask

   task automatic apb_read(input addr_t addr);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
      apb_req.paddr   = addr;
      @(posedge clk);
      #1;
      apb_req.penable = 1'b1;
      @(negedge clk);
      while (!pready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      apb_req = '0;
      read_count++;
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (xfer_count < write_count && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
   endtask

   task automatic finish_test(input string name);
      if (xfer_count != write_count) begin
         $display("Mismatch at %0t: xfer_count = %0d, write_count = %0d",
                  $time, xfer_count, write_count);
         tb_errors++;
      end
      $display("%-24s writes %0d transfers %0d errors %0d", name, write_count,
               xfer_count, tb_errors + dut_i.chk_i.fail_count);
   endtask

   initial begin
      apb_req  = '0;
      be_ready = 1'b0;
      reset    = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      @(posedge clk);
      #1;
      finish_test("reset release");

      ready_mode = 1;
      for (int i = 0; i < LANES; i++) begin
         apb_write(addr_t'(32'h0000_0100 + 4 * i));   // one store per lane
      end
      wait_drained();
      finish_test("lane placement");

      ready_mode = 2;
      for (int i = 0; i < 16; i++) begin
         apb_write(addr_t'(32'h0000_3000 + 20 * i));
      end
      wait_drained();
      finish_test("random backpressure");

      ready_mode  = 0;
      stall_count = 0;
      fork
         begin
            for (int i = 0; i < 12; i++) begin
               apb_write(addr_t'(32'h0000_5000 + 4 * i));
            end
         end
         begin
            repeat (24) @(posedge clk);
            #1;
            ready_mode = 1;   // release the backend
         end
      join
      wait_drained();
      if (stall_count == 0) begin
         $display("full buffer never stalled the APB writes");
         tb_errors++;
      end
      finish_test("burst with full buffer");

      apb_read(addr_t'(32'h0000_0100));
      repeat (10) @(posedge clk);
      #1;
      finish_test("read rejected");

      $display("totals: writes %0d reads %0d transfers %0d errors %0d", write_count,
               read_count, xfer_count, tb_errors + dut_i.chk_i.fail_count);
      if (tb_errors == 0 && dut_i.chk_i.fail_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* tb/wt_store_path_assertions.sv */
`timescale 1ns/1ps

module wt_store_path_assertions
   import cache_req_pkg::*;
   import be_bus_pkg::*;
(
   input logic              clk,
   input logic              reset,
   input apb_req_t          apb_req,
   input logic              pready,
   input logic              pslverr,
   input logic [DATA_W-1:0] prdata,
   input be_req_t           be_req,
   input logic              be_ready
);

   localparam logic [31:0] DATA_KEY = 32'h5a5a_0000;
   localparam int          PEND_N   = 16;
   localparam int          PEND_W   = $clog2(PEND_N);

   int                fail_count = 0;
   logic              xfer;
   logic [LANES-1:0]  lane_hit;
   logic [LANE_W-1:0] lane;
   waddr_t            waddr;
   word_t             exp_word;
   word_t             lane_word;
   be_strb_t          exp_strb;
   addr_t             pend_addr [PEND_N];   // completed APB writes, oldest at pend_rd
   logic [PEND_W-1:0] pend_wr;
   logic [PEND_W-1:0] pend_rd;
   be_addr_t          exp_addr;

   assign xfer = be_req.valid & be_ready;

   // lane is taken from the strobe
   always_comb begin
      lane = '0;
      for (int i = 0; i < LANES; i++) begin
         lane_hit[i] = |be_req.wstrb[i*NBYTES +: NBYTES];
         if (lane_hit[i]) begin
            lane = LANE_W'(i);
         end
      end
   end

   always @(posedge clk, posedge reset) begin
      if (reset) begin
         pend_wr <= '0;
         pend_rd <= '0;
      end else begin
         if (apb_req.psel && apb_req.penable && apb_req.pwrite && pready) begin
            pend_addr[pend_wr] <= apb_req.paddr;
            pend_wr            <= pend_wr + 1'b1;
         end
         if (xfer) begin
            pend_rd <= pend_rd + 1'b1;
         end
      end
   end

   assign exp_addr  = {pend_addr[pend_rd][ADDR_W-1:BE_NBYTES_W], {BE_NBYTES_W{1'b0}}};
   assign waddr     = {be_req.addr[BE_ADDR_W-1:BE_NBYTES_W], lane};
   assign exp_word  = DATA_W'(waddr) ^ DATA_KEY;   // stored word rule
   assign lane_word = be_req.wdata[lane*DATA_W +: DATA_W];
   assign exp_strb  = be_strb_t'({waddr[0], ~waddr[0], waddr[1], 1'b1}) << (lane * NBYTES);

   a_reset_idle: assert property (@(posedge clk)
      $fell(reset) |-> !be_req.valid && !pready && !pslverr)
      else begin
         fail_count++;
         $error("outputs not idle at reset release");
      end

   // backend beats leave in APB order
   a_addr: assert property (@(posedge clk) disable iff (reset)
      xfer |-> be_req.addr == exp_addr)
      else begin
         fail_count++;
         $error("Mismatch at %0t: be_req.addr = %h, expected %h", $time, be_req.addr, exp_addr);
      end

   a_one_lane: assert property (@(posedge clk) disable iff (reset)
      xfer |-> $onehot(lane_hit))
      else begin
         fail_count++;
         $error("strobe of transfer does not select exactly one lane");
      end

   a_strb: assert property (@(posedge clk) disable iff (reset)
      xfer |-> be_req.wstrb == exp_strb)
      else begin
         fail_count++;
         $error("Mismatch at %0t: be_req.wstrb = %h, expected %h", $time, be_req.wstrb, exp_strb);
      end

   a_data: assert property (@(posedge clk) disable iff (reset)
      xfer |-> lane_word == exp_word)
      else begin
         fail_count++;
         $error("Mismatch at %0t: be_req.wdata lane = %h, expected %h", $time, lane_word, exp_word);
      end

   // request frozen while stalled
   a_hold: assert property (@(posedge clk) disable iff (reset)
      be_req.valid && !be_ready |=> $stable(be_req))
      else begin
         fail_count++;
         $error("backend request changed while waiting on be_ready");
      end

   a_read_err: assert property (@(posedge clk) disable iff (reset)
      apb_req.psel && apb_req.penable && !apb_req.pwrite |-> pready && pslverr && prdata == '0)
      else begin
         fail_count++;
         $error("APB read did not complete at once with an error response");
      end

   a_write_ok: assert property (@(posedge clk) disable iff (reset)
      apb_req.psel && apb_req.penable && apb_req.pwrite && pready |-> !pslverr)
      else begin
         fail_count++;
         $error("APB write completed with an error response");
      end

endmodule

/* design/wt_store_path.sv */
`timescale 1ns/1ps

module wt_store_path
   import cache_req_pkg::*;
   import be_bus_pkg::*;
#(
   parameter int WBUF_DEPTH = 4
) (
   input  logic              clk,
   input  logic              reset,

   // CPU side APB
   input  apb_req_t          apb_req,
   output logic              pready,
   output logic              pslverr,
   output logic [DATA_W-1:0] prdata,

   // backend memory
   output be_req_t           be_req,
   input  logic              be_ready
);

   logic   push;
   store_t push_data;
   logic   pop;
   store_t head;
   logic   full;
   logic   empty;

   apb_store_port port_i (
      .clk       (clk),
      .reset     (reset),
      .apb_req   (apb_req),
      .pready    (pready),
      .pslverr   (pslverr),
      .prdata    (prdata),
      .full      (full),
      .push      (push),
      .push_data (push_data)
   );

   store_buffer #(
      .WBUF_DEPTH (WBUF_DEPTH)
   ) wbuf_i (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .head      (head),
      .full      (full),
      .empty     (empty)
   );

   write_channel wchan_i (
      .clk      (clk),
      .reset    (reset),
      .empty    (empty),
      .head     (head),
      .pop      (pop),
      .be_req   (be_req),
      .be_ready (be_ready)
   );

endmodule

/* design/write_channel.sv */
`timescale 1ns/1ps

module write_channel
   import cache_req_pkg::*;
   import be_bus_pkg::*;
(
   input  logic    clk,
   input  logic    reset,

   // write buffer head
   input  logic    empty,
   input  store_t  head,
   output logic    pop,

   // backend memory bus
   output be_req_t be_req,
   input  logic    be_ready
);

   typedef enum logic {
      S_IDLE,
      S_WRITE
   } state_t;

   state_t state;
   state_t state_nxt;

   logic              xfer;
   logic              load;
   logic [LANE_W-1:0] lane;
   be_addr_t          addr_q;
   be_data_t          wdata_q;
   be_strb_t          wstrb_q;
   be_strb_t          strb_ext;

   assign xfer = (state == S_WRITE) & be_ready;

   // take the head when idle or when the current beat leaves
   assign load = ~empty & ((state == S_IDLE) | xfer);
   assign pop  = load;

   assign lane     = head.addr[LANE_W-1:0];
   assign strb_ext = {{(BE_NBYTES-NBYTES){1'b0}}, head.wstrb};

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (~empty) begin
               state_nxt = S_WRITE;
            end
         end
         default: begin
            if (be_ready & empty) begin
               state_nxt = S_IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state <= S_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // request payload, held while waiting on be_ready
   always_ff @(posedge clk) begin
      if (load) begin
         addr_q  <= be_addr_t'({head.addr[WADDR_W-1:LANE_W], {BE_NBYTES_W{1'b0}}});
         wdata_q <= {LANES{head.wdata}};      // same word on every lane
         wstrb_q <= strb_ext << (lane * NBYTES);
      end
   end

   always_comb begin
      be_req.valid = (state == S_WRITE);
      be_req.addr  = addr_q;
      be_req.wdata = wdata_q;
      be_req.wstrb = wstrb_q;
   end

endmodule

/* design/apb_store_port.sv */
`timescale 1ns/1ps

module apb_store_port
   import cache_req_pkg::*;
(
   input  logic              clk,
   input  logic              reset,

   // APB slave side
   input  apb_req_t          apb_req,
   output logic              pready,
   output logic              pslverr,
   output logic [DATA_W-1:0] prdata,

   // write buffer side
   input  logic              full,
   output logic              push,
   output store_t            push_data
);

   logic setup;
   logic access;
   logic rd_err_q;

   assign setup  = apb_req.psel & ~apb_req.penable;
   assign access = apb_req.psel & apb_req.penable;

   // reads finish at once, writes wait for a free buffer slot
   assign pready = access & (~apb_req.pwrite | ~full);

   assign push = access & apb_req.pwrite & ~full;

   always_comb begin
      push_data.addr  = apb_req.paddr[ADDR_W-1:NBYTES_W];
      push_data.wdata = apb_req.pwdata;
      push_data.wstrb = apb_req.pstrb;
   end

   // read data path not implemented
   assign prdata = '0;

   // flag a read seen in setup, so it lands on its only access cycle
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         rd_err_q <= 1'b0;
      end else begin
         rd_err_q <= setup & ~apb_req.pwrite;
      end
   end

   assign pslverr = rd_err_q;

endmodule

/* design/store_buffer.sv */
`timescale 1ns/1ps

module store_buffer
   import cache_req_pkg::*;
#(
   parameter int WBUF_DEPTH = 4
) (
   input  logic   clk,
   input  logic   reset,

   input  logic   push,
   input  store_t push_data,

   input  logic   pop,
   output store_t head,

   output logic   full,
   output logic   empty
);

   localparam int IDX_W = $clog2(WBUF_DEPTH);

   store_t           mem [WBUF_DEPTH];
   logic [IDX_W:0]   wr_ptr;   // extra msb tells full from empty
   logic [IDX_W:0]   rd_ptr;
   logic [IDX_W-1:0] wr_idx;
   logic [IDX_W-1:0] rd_idx;
   logic             do_push;
   logic             do_pop;

   assign wr_idx = wr_ptr[IDX_W-1:0];
   assign rd_idx = rd_ptr[IDX_W-1:0];

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) && (wr_idx == rd_idx);

   // a full buffer still takes a push when the head leaves in the same cycle
   assign do_pop  = pop & ~empty;
   assign do_push = push & (~full | do_pop);

   assign head = mem[rd_idx];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_idx] <= push_data;
      end
   end

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

/* design/be_bus_pkg.sv */
package be_bus_pkg;

   // backend memory bus sizes
   localparam int BE_ADDR_W   = 32;
   localparam int BE_DATA_W   = 128;
   localparam int BE_NBYTES   = BE_DATA_W / 8;
   localparam int BE_NBYTES_W = $clog2(BE_NBYTES);

   // CPU words packed in one backend word
   localparam int LANES  = 4;
   localparam int LANE_W = $clog2(LANES);

   typedef logic [BE_ADDR_W-1:0] be_addr_t;
   typedef logic [BE_DATA_W-1:0] be_data_t;
   typedef logic [BE_NBYTES-1:0] be_strb_t;

   // single beat write request, held until be_ready
   typedef struct packed {
      logic     valid;
      be_addr_t addr;    // aligned to the backend word
      be_data_t wdata;
      be_strb_t wstrb;
   } be_req_t;

endpackage

/* design/cache_req_pkg.sv */
package cache_req_pkg;

   // CPU side sizes
   localparam int ADDR_W   = 32;          // byte address
   localparam int DATA_W   = 32;          // CPU word
   localparam int NBYTES   = DATA_W / 8;
   localparam int NBYTES_W = $clog2(NBYTES);

   // word address, byte offset dropped
   localparam int WADDR_W  = ADDR_W - NBYTES_W;

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [DATA_W-1:0]  word_t;
   typedef logic [NBYTES-1:0]  strb_t;
   typedef logic [WADDR_W-1:0] waddr_t;

   // driven by the APB master, one access at a time
   typedef struct packed {
      logic  psel;
      logic  penable;
      logic  pwrite;
      addr_t paddr;
      word_t pwdata;
      strb_t pstrb;
   } apb_req_t;

   // one pending store as it sits in the write buffer
   typedef struct packed {
      waddr_t addr;   // word address
      word_t  wdata;
      strb_t  wstrb;
   } store_t;

endpackage
